// ==== rtl/itm_pkg.sv ====
package itm_pkg;

   // timestamp and program counter widths
   localparam int timestamp_width = 16;
   localparam int pc_width = 32;

   // one trace entry is timestamp plus pc
   localparam int trace_width = timestamp_width + pc_width;

   // clk_sample cycles per timestamp tick
   localparam int ts_prescale = 4;
   localparam int prescale_width = $clog2(ts_prescale);

   // ring buffer geometry, depth must stay a power of two
   localparam int buf_depth = 16;
   localparam int buf_addr_width = 4;

   // credits held by the readout after reset
   localparam int read_credits = 4;
   // wide enough to hold the full credit count itself
   localparam int credit_width = $clog2(read_credits + 1);

   // saturating loss counter width
   localparam int lost_width = 16;

   // credit counter type
   typedef logic [credit_width-1:0] credit_t;

   // trace entry, timestamp in the upper bits
   typedef struct packed {
      logic [timestamp_width-1:0] timestamp;
      logic [pc_width-1:0] pc;
   } trace_entry_t;

endpackage

// ==== rtl/itm_timestamp_provider.sv ====
`timescale 1ns/1ps

module itm_timestamp_provider (
   input logic clk_sample,
   input logic rst,
   // global time, in prescaled ticks
   output logic [itm_pkg::timestamp_width-1:0] timestamp
);

   // cycles seen within the current tick
   logic [itm_pkg::prescale_width-1:0] prescale_cnt;
   // last cycle of a tick
   logic tick_end;

   assign tick_end = (prescale_cnt == itm_pkg::ts_prescale - 1);

   // prescaler
   always_ff @(posedge clk_sample or posedge rst) begin
      if (rst) begin
         prescale_cnt <= '0;
      end else if (tick_end) begin
         prescale_cnt <= '0;
      end else begin
         prescale_cnt <= prescale_cnt + 1'b1;
      end
   end

   // timestamp moves once per prescale period
   // wraps at the top of its range
   always_ff @(posedge clk_sample or posedge rst) begin
      if (rst) begin
         timestamp <= '0;
      end else if (tick_end) begin
         timestamp <= timestamp + 1'b1;
      end
   end

endmodule

// ==== rtl/itm_trace_collector.sv ====
`timescale 1ns/1ps

module itm_trace_collector (
   input logic clk_sample,
   input logic rst,
   // write-back stage of the traced core
   input logic [itm_pkg::pc_width-1:0] cpu_wb_pc,
   input logic cpu_wb_freeze,
   // from the timestamp provider
   input logic [itm_pkg::timestamp_width-1:0] timestamp,
   // toward the ring buffer, one entry per unfrozen cycle
   output logic trace_valid,
   output itm_pkg::trace_entry_t trace_entry
);

   // next entry, built from the current pc and time
   itm_pkg::trace_entry_t next_entry;

   always_comb begin
      next_entry.timestamp = timestamp;
      next_entry.pc = cpu_wb_pc;
   end

   // registered capture
   // valid for exactly the cycle after the sampled edge
   always_ff @(posedge clk_sample or posedge rst) begin
      if (rst) begin
         trace_entry <= '0;
         trace_valid <= 1'b0;
      end else begin
         if (!cpu_wb_freeze) begin
            trace_entry <= next_entry;
            trace_valid <= 1'b1;
         end else begin
            // frozen core, nothing to report
            trace_entry <= '0;
            trace_valid <= 1'b0;
         end
      end
   end

   // no back-pressure here
   // the ring buffer always takes the entry, overwriting if it must

endmodule

// ==== rtl/itm_ring_buffer.sv ====
`timescale 1ns/1ps

module itm_ring_buffer (
   input logic clk_sample,
   input logic rst,
   // from the collector
   input logic trace_valid,
   input itm_pkg::trace_entry_t trace_entry,
   // readout side
   input logic pop,
   output logic buf_empty,
   output itm_pkg::trace_entry_t head_entry,
   // entries dropped on overflow, saturating
   output logic [itm_pkg::lost_width-1:0] lost_count
);

   // trace storage
   itm_pkg::trace_entry_t mem [itm_pkg::buf_depth];

   // pointers wrap on their own, depth is a power of two
   logic [itm_pkg::buf_addr_width-1:0] wr_ptr;
   logic [itm_pkg::buf_addr_width-1:0] rd_ptr;

   // occupancy, one extra bit so full is visible
   logic [itm_pkg::buf_addr_width:0] count;

   logic buf_full;
   // qualified pop, never on an empty buffer
   logic do_read;
   // write into a full buffer without a pop
   logic overwrite;
   // loss counter at its top value
   logic lost_max;

   assign buf_empty = (count == '0);
   assign buf_full = (count == itm_pkg::buf_depth);
   assign do_read = pop && !buf_empty;

   // pop wins over overflow on the same edge
   assign overwrite = trace_valid && buf_full && !do_read;

   assign lost_max = (lost_count == {itm_pkg::lost_width{1'b1}});

   // oldest entry shown to the readout
   assign head_entry = mem[rd_ptr];

   // storage write
   // when full, wr_ptr equals rd_ptr and the oldest slot is replaced
   always_ff @(posedge clk_sample) begin
      if (trace_valid) begin
         mem[wr_ptr] <= trace_entry;
      end
   end

   // write pointer
   always_ff @(posedge clk_sample or posedge rst) begin
      if (rst) begin
         wr_ptr <= '0;
      end else if (trace_valid) begin
         wr_ptr <= wr_ptr + 1'b1;
      end
   end

   // read pointer
   // moves on a pop, or on overwrite to skip the lost entry
   always_ff @(posedge clk_sample or posedge rst) begin
      if (rst) begin
         rd_ptr <= '0;
      end else if (do_read || overwrite) begin
         rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // occupancy
   always_ff @(posedge clk_sample or posedge rst) begin
      if (rst) begin
         count <= '0;
      end else begin
         if (trace_valid && !do_read && !buf_full) begin
            count <= count + 1'b1;
         end else if (do_read && !trace_valid) begin
            count <= count - 1'b1;
         end
         // write plus pop, or overwrite, keeps the count
      end
   end

   // loss counter
   // stops at its maximum instead of wrapping
   always_ff @(posedge clk_sample or posedge rst) begin
      if (rst) begin
         lost_count <= '0;
      end else if (overwrite && !lost_max) begin
         lost_count <= lost_count + 1'b1;
      end
   end

endmodule

// ==== rtl/itm_readout.sv ====
`timescale 1ns/1ps

module itm_readout (
   input logic clk_sample,
   input logic rst,
   // ring buffer side
   input logic buf_empty,
   input itm_pkg::trace_entry_t head_entry,
   output logic pop,
   // host side, credit based
   input logic credit_return,
   output logic out_valid,
   output itm_pkg::trace_entry_t out_entry
);

   // credits currently held
   itm_pkg::credit_t credits;

   logic have_credit;
   // entry goes out on this edge
   logic send;
   // returned credit that fits under the limit
   logic take_credit;

   assign have_credit = (credits != '0);
   assign send = have_credit && !buf_empty;

   // pop the head in the same cycle it gets registered
   assign pop = send;

   // never count beyond the reset value
   assign take_credit = credit_return && (credits < itm_pkg::read_credits);

   // credit counter
   always_ff @(posedge clk_sample or posedge rst) begin
      if (rst) begin
         credits <= itm_pkg::credit_t'(itm_pkg::read_credits);
      end else begin
         if (send && !credit_return) begin
            credits <= credits - 1'b1;
         end else if (!send && take_credit) begin
            credits <= credits + 1'b1;
         end
         // send and return together cancel out
      end
   end

   // output strobe, one cycle per sent entry
   always_ff @(posedge clk_sample or posedge rst) begin
      if (rst) begin
         out_valid <= 1'b0;
      end else begin
         out_valid <= send;
      end
   end

   // payload register
   // only meaningful while out_valid is high
   always_ff @(posedge clk_sample) begin
      if (send) begin
         out_entry <= head_entry;
      end
   end

endmodule

// ==== rtl/itm_top.sv ====
`timescale 1ns/1ps

module itm_top (
   input logic clk_sample,
   input logic rst,
   // traced core
   input logic [itm_pkg::pc_width-1:0] cpu_wb_pc,
   input logic cpu_wb_freeze,
   // debug host
   input logic credit_return,
   output logic out_valid,
   output itm_pkg::trace_entry_t out_entry,
   // overflow statistics
   output logic [itm_pkg::lost_width-1:0] lost_count
);

   // global time
   logic [itm_pkg::timestamp_width-1:0] timestamp;

   // collector to ring buffer
   logic trace_valid;
   itm_pkg::trace_entry_t trace_entry;

   // ring buffer to readout
   logic buf_empty;
   logic pop;
   itm_pkg::trace_entry_t head_entry;

   itm_timestamp_provider timestamp_provider_i (
      .clk_sample (clk_sample),
      .rst        (rst),
      .timestamp  (timestamp)
   );

   itm_trace_collector trace_collector_i (
      .clk_sample    (clk_sample),
      .rst           (rst),
      .cpu_wb_pc     (cpu_wb_pc),
      .cpu_wb_freeze (cpu_wb_freeze),
      .timestamp     (timestamp),
      .trace_valid   (trace_valid),
      .trace_entry   (trace_entry)
   );

   itm_ring_buffer ring_buffer_i (
      .clk_sample  (clk_sample),
      .rst         (rst),
      .trace_valid (trace_valid),
      .trace_entry (trace_entry),
      .pop         (pop),
      .buf_empty   (buf_empty),
      .head_entry  (head_entry),
      .lost_count  (lost_count)
   );

   itm_readout readout_i (
      .clk_sample    (clk_sample),
      .rst           (rst),
      .buf_empty     (buf_empty),
      .head_entry    (head_entry),
      .pop           (pop),
      .credit_return (credit_return),
      .out_valid     (out_valid),
      .out_entry     (out_entry)
   );

endmodule

// ==== dv/itm_tb.sv ====
`timescale 1ns/1ps

module itm_tb;

   typedef logic [itm_pkg::lost_width-1:0] lost_t;
   typedef logic [itm_pkg::timestamp_width-1:0] ts_t;
   typedef logic [itm_pkg::pc_width-1:0] pc_t;

   // one row of the stimulus table
   typedef struct {
      int cycles;
      int freeze_mode;
      int give_credits;
      int exp_loss;
      int drain;
      int rst_before;
   } phase_t;

   // freeze patterns
   localparam int frz_always = 0;
   localparam int frz_never = 1;
   localparam int frz_random = 2;

   localparam int num_phases = 7;
   // cycles allowed for any single wait
   localparam int wait_limit = 40;

   logic clk_sample;
   logic rst;
   pc_t cpu_wb_pc;
   logic cpu_wb_freeze;
   logic credit_return;
   logic out_valid;
   itm_pkg::trace_entry_t out_entry;
   lost_t lost_count;

   // reference model of the buffer path
   itm_pkg::trace_entry_t model_q[$];
   itm_pkg::trace_entry_t pend_e;
   itm_pkg::trace_entry_t exp_out;
   logic pend_v;
   logic exp_send;
   int credits_m;
   lost_t lost_m;
   // rising edges since reset release
   int edge_n;

   // credits the host still owes back to the DUT
   int owed;
   logic got_valid;

   logic [31:0] rng_state;
   logic drv_freeze;
   pc_t drv_pc;
   phase_t phases [num_phases];
   int ph;
   int cyc;
   lost_t lost_start;

   itm_top itm_top_i (
      .clk_sample    (clk_sample),
      .rst           (rst),
      .cpu_wb_pc     (cpu_wb_pc),
      .cpu_wb_freeze (cpu_wb_freeze),
      .credit_return (credit_return),
      .out_valid     (out_valid),
      .out_entry     (out_entry),
      .lost_count    (lost_count)
   );

   // 20 ns period
   always #10 clk_sample = ~clk_sample;

   task automatic abort_run();
      $display("Testbench failed");
      $fatal(1);
   endtask

   task automatic fail_with_reason(input string msg);
      $display("%s", msg);
      abort_run();
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_entry(input string name, input itm_pkg::trace_entry_t exp,
                              input itm_pkg::trace_entry_t act);
      if (act !== exp) begin
         $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_count(input string name, input lost_t exp, input lost_t act);
      if (act !== exp) begin
         $display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
         abort_run();
      end
   endtask

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   // random pc and a freeze bit per pattern
   task automatic pick_stimulus(input int mode);
      rng_state = lcg_next(rng_state);
      drv_pc = pc_t'(rng_state);
      rng_state = lcg_next(rng_state);
      if (mode == frz_always) begin
         drv_freeze = 1'b1;
      end else if (mode == frz_never) begin
         drv_freeze = 1'b0;
      end else begin
         // roughly one frozen cycle in four
         drv_freeze = (rng_state[31:30] == 2'b00);
      end
   endtask

   // one rising edge of the trace path
   task automatic model_edge(input logic freeze, input pc_t pc, input logic cr);
      logic send;
      send = (credits_m > 0) && (model_q.size() > 0);
      exp_send = send;
      if (send) begin
         exp_out = model_q.pop_front();
      end
      // entry captured one edge earlier lands now
      // pop already made room if there was one
      if (pend_v) begin
         if (model_q.size() == itm_pkg::buf_depth) begin
            void'(model_q.pop_front());
            if (lost_m != '1) begin
               lost_m = lost_m + 1'b1;
            end
         end
         model_q.push_back(pend_e);
      end
      // send plus return leaves credits alone
      if (send && !cr) begin
         credits_m = credits_m - 1;
      end else if (!send && cr && credits_m < itm_pkg::read_credits) begin
         credits_m = credits_m + 1;
      end
      pend_v = !freeze;
      pend_e.timestamp = ts_t'(edge_n / itm_pkg::ts_prescale);
      pend_e.pc = pc;
      edge_n = edge_n + 1;
   endtask

   // drive on the falling edge and check on the next one
   task automatic run_cycle(input logic freeze, input pc_t pc, input int give);
      logic cr;
      cr = (give != 0) && (owed > 0);
      if (cr) begin
         owed = owed - 1;
      end
      cpu_wb_freeze = freeze;
      cpu_wb_pc = pc;
      credit_return = cr;
      @(posedge clk_sample);
      model_edge(freeze, pc, cr);
      @(negedge clk_sample);
      check_flag("out_valid", exp_send, out_valid);
      if (exp_send) begin
         check_entry("out_entry", exp_out, out_entry);
      end
      check_count("lost_count", lost_m, lost_count);
      got_valid = out_valid;
      // host owes one credit per received entry
      if (out_valid) begin
         owed = owed + 1;
      end
   endtask

   task automatic wait_out_valid();
      int waited;
      waited = 0;
      got_valid = 1'b0;
      while (!got_valid) begin
         if (waited == wait_limit) begin
            fail_with_reason("timeout while waiting for out_valid from the readout");
         end
         pick_stimulus(frz_always);
         run_cycle(drv_freeze, drv_pc, 1);
         waited = waited + 1;
      end
   endtask

   // empty the buffer and then hand back all withheld credits
   task automatic drain_backlog();
      int waited;
      while (model_q.size() > 0 || pend_v) begin
         wait_out_valid();
      end
      waited = 0;
      while (owed > 0) begin
         if (waited == wait_limit) begin
            fail_with_reason("timeout while handing credits back to the readout");
         end
         run_cycle(1'b1, '0, 1);
         waited = waited + 1;
      end
   endtask

   task automatic apply_reset();
      rst = 1'b1;
      cpu_wb_freeze = 1'b1;
      credit_return = 1'b0;
      repeat (16) @(negedge clk_sample);
      model_q.delete();
      pend_v = 1'b0;
      exp_send = 1'b0;
      credits_m = itm_pkg::read_credits;
      lost_m = '0;
      edge_n = 0;
      owed = 0;
      check_flag("out_valid", 1'b0, out_valid);
      check_count("lost_count", '0, lost_count);
      // next rising edge is edge 0
      rst = 1'b0;
   endtask

   initial begin
      clk_sample = 1'b0;
      rst = 1'b1;
      cpu_wb_pc = '0;
      cpu_wb_freeze = 1'b1;
      credit_return = 1'b0;
      rng_state = 32'd43967;

      // cycles, freeze, credits, loss, drain, reset first
      // idle core so nothing may come out
      phases[0] = '{40, frz_always, 1, 0, 0, 0};
      // back to back entries
      phases[1] = '{60, frz_never, 1, 0, 1, 0};
      // sparse frozen cycles
      phases[2] = '{80, frz_random, 1, 0, 1, 0};
      // credits held back so only read_credits entries come out
      phases[3] = '{8, frz_never, 0, 0, 0, 0};
      // buffer overflows with 27 losses here and one more in the drain
      phases[4] = '{40, frz_never, 0, 28, 1, 0};
      // backlog left in place for the reset
      phases[5] = '{12, frz_never, 0, 0, 0, 0};
      // stream again after reset with timestamps from 0
      phases[6] = '{30, frz_never, 1, 0, 1, 1};

      apply_reset();

      for (ph = 0; ph < num_phases; ph++) begin
         if (phases[ph].rst_before != 0) begin
            apply_reset();
         end
         lost_start = lost_count;
         for (cyc = 0; cyc < phases[ph].cycles; cyc++) begin
            pick_stimulus(phases[ph].freeze_mode);
            run_cycle(drv_freeze, drv_pc, phases[ph].give_credits);
         end
         if (phases[ph].drain != 0) begin
            drain_backlog();
         end
         check_count("lost_count increase", lost_t'(phases[ph].exp_loss),
                     lost_t'(lost_count - lost_start));
      end

      $display("Testbench passed");
      $finish;
   end

endmodule

// ==== verilog.f ====
rtl/itm_pkg.sv
rtl/itm_timestamp_provider.sv
rtl/itm_trace_collector.sv
rtl/itm_ring_buffer.sv
rtl/itm_readout.sv
rtl/itm_top.sv
dv/itm_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the trace unit testbench with Verilator and runs it
# the result comes from the simulation log

cd "$(dirname "$0")" || exit 1

log=sim.log
rm -rf obj_dir "$log" build.log

verilator --binary --timing -Wno-fatal --top-module itm_tb -f verilog.f -o itm_sim \
   > build.log 2>&1 \
   && ./obj_dir/itm_sim > "$log" 2>&1 \
   || echo "build or simulation ended with an error, see build.log and $log"

[ -f "$log" ] && cat "$log"

grep -qx "Testbench passed" "$log" 2>/dev/null \
   && echo "simulation result: pass" \
   || { echo "simulation result: fail"; exit 1; }
